/* instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
	input issue_pkg::word_t instr,
	output issue_pkg::decoded_t dec
);
	import issue_pkg::*;

	opcode_t opcode;
	word_t sext6;

	assign opcode = opcode_t'(instr[15:12]);
	assign sext6 = {{(WORD_W-6){instr[5]}}, instr[5:0]};

	always_comb
	begin
		dec.opcode = opcode;
		dec.dest = instr[11:9];
		dec.sr1 = instr[8:6];
		dec.sr2 = instr[2:0];

		// SHF always carries its amount in the low bits
		dec.use_imm = instr[5] || (opcode == op_shf);
		dec.imm5 = {{(WORD_W-5){instr[4]}}, instr[4:0]};

		case (opcode)
			op_add, op_and, op_not, op_shf:
				dec.op_class = class_alu;
			op_ldr, op_ldb:
				dec.op_class = class_load;
			op_str, op_stb:
				dec.op_class = class_store;
			default:
				dec.op_class = class_none;
		endcase

		// Word accesses address in units of two bytes
		if (opcode == op_ldr || opcode == op_str)
			dec.offset = sext6 << 1;
		else
			dec.offset = sext6;	// Byte form
	end

endmodule

/* issue_control.sv */
`timescale 1ns/1ps

module issue_control (
	input logic instr_is_new,
	input issue_pkg::decoded_t dec,
	input logic [issue_pkg::NUM_ALU_STATIONS-1:0] alu_busy,
	input logic ldst_full,
	input logic rob_full,
	input issue_pkg::rob_tag_t rob_addr,
	input issue_pkg::reg_entry_t sr1_entry,
	input issue_pkg::reg_entry_t src_entry,
	input issue_pkg::operand_t opnd_a,
	input issue_pkg::operand_t opnd_b,
	output logic stall,
	output logic sel_src_reg,
	output issue_pkg::rob_tag_t rob_sr1_addr,
	output issue_pkg::rob_tag_t rob_sr2_addr,
	output logic rename_en,
	output issue_pkg::reg_idx_t rename_reg,
	output issue_pkg::rob_tag_t rename_tag,
	output issue_pkg::rs_write_t rs_write,
	output issue_pkg::ldst_write_t ldst_write,
	output issue_pkg::rob_write_t rob_write
);
	import issue_pkg::*;

	logic is_alu;
	logic is_load;
	logic is_store;
	logic is_mem;
	logic all_busy;
	logic issue;
	station_id_t free_station;
	operand_t imm_opnd;

	assign is_alu = (dec.op_class == class_alu);
	assign is_load = (dec.op_class == class_load);
	assign is_store = (dec.op_class == class_store);
	assign is_mem = is_load || is_store;
	assign all_busy = &alu_busy;

	// Unsupported opcodes never stall
	assign stall = instr_is_new &&
		((rob_full && (is_alu || is_mem)) ||
		(all_busy && is_alu) ||
		(ldst_full && is_mem));

	assign issue = instr_is_new && !stall && (is_alu || is_mem);

	// Stores read their source through the second resolver
	assign sel_src_reg = is_store;

	assign rob_sr1_addr = sr1_entry.rob_entry;
	assign rob_sr2_addr = src_entry.rob_entry;	// Dest tag for stores, sr2 tag otherwise

	always_comb
	begin
		free_station = '0;
		// Walk down so the lowest free one is kept
		for (int i = NUM_ALU_STATIONS - 1; i >= 0; i--)
		begin
			if (!alu_busy[i])
				free_station = station_id_t'(i);
		end
	end

	always_comb
	begin
		imm_opnd = '0;
		imm_opnd.ready = 1'b1;
		imm_opnd.value = dec.imm5;
	end

	// Stores produce no register value
	assign rename_en = issue && (is_alu || is_load);
	assign rename_reg = dec.dest;
	assign rename_tag = rob_addr;

	always_comb
	begin
		rs_write = '0;
		ldst_write = '0;
		rob_write = '0;

		if (issue)
		begin
			rob_write.enable = 1'b1;
			rob_write.opcode = dec.opcode;
			rob_write.dest = is_store ? reg_idx_t'(0) : dec.dest;

			if (is_alu)
			begin
				rs_write.enable = 1'b1;
				rs_write.station = free_station;
				rs_write.opcode = dec.opcode;
				rs_write.dest = rob_addr;
				rs_write.j = opnd_a;
				rs_write.k = dec.use_imm ? imm_opnd : opnd_b;
			end
			else
			begin
				ldst_write.enable = 1'b1;
				ldst_write.opcode = dec.opcode;
				ldst_write.dest = is_store ? rob_tag_t'(0) : rob_addr;
				ldst_write.offset = dec.offset;
				ldst_write.base = opnd_a;
				if (is_store)
					ldst_write.src = opnd_b;	// Value to be written to memory
			end
		end
	end

endmodule

/* issue_pkg.sv */
package issue_pkg;

	localparam int WORD_W = 16;
	localparam int REG_W = 3;
	localparam int TAG_W = 3;
	localparam int STATION_W = 2;

	localparam int NUM_REGS = 8;
	localparam int NUM_ALU_STATIONS = 3;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0] reg_idx_t;
	typedef logic [TAG_W-1:0] rob_tag_t;	// Eight ROB entries
	typedef logic [STATION_W-1:0] station_id_t;

	// LC-3b opcode field, bits 15:12
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} opcode_t;

	typedef enum logic [1:0] {
		class_alu   = 2'd0,
		class_load  = 2'd1,
		class_store = 2'd2,
		class_none  = 2'd3
	} op_class_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		word_t data;
	} cdb_t;

	// Value is good when ready, else tag names the producer
	typedef struct packed {
		logic ready;
		word_t value;
		rob_tag_t tag;
	} operand_t;

	typedef struct packed {
		logic busy;
		word_t data;
		rob_tag_t rob_entry;
	} reg_entry_t;

	typedef struct packed {
		logic valid;
		reg_idx_t dest;
		rob_tag_t tag;
		word_t data;
	} commit_t;

	typedef struct packed {
		opcode_t opcode;
		op_class_t op_class;
		reg_idx_t dest;
		reg_idx_t sr1;
		reg_idx_t sr2;
		logic use_imm;
		word_t imm5;	// Already sign-extended
		word_t offset;	// Scaled for word accesses
	} decoded_t;

	typedef struct packed {
		logic enable;
		station_id_t station;
		opcode_t opcode;
		rob_tag_t dest;
		operand_t j;
		operand_t k;
	} rs_write_t;

	typedef struct packed {
		logic enable;
		opcode_t opcode;
		rob_tag_t dest;	// Zero for stores
		word_t offset;
		operand_t base;
		operand_t src;
	} ldst_write_t;

	typedef struct packed {
		logic enable;
		opcode_t opcode;
		reg_idx_t dest;
	} rob_write_t;

endpackage

/* issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
	input logic clk,
	input logic rst_n,
	input issue_pkg::word_t instr,
	input logic instr_is_new,
	input issue_pkg::cdb_t cdb,
	input logic [issue_pkg::NUM_ALU_STATIONS-1:0] alu_busy,
	input logic ldst_full,
	input logic rob_full,
	input issue_pkg::rob_tag_t rob_addr,
	input issue_pkg::operand_t rob_sr1,
	input issue_pkg::operand_t rob_sr2,
	input issue_pkg::commit_t commit,
	output logic stall,
	output issue_pkg::rob_tag_t rob_sr1_addr,
	output issue_pkg::rob_tag_t rob_sr2_addr,
	output issue_pkg::rs_write_t rs_write,
	output issue_pkg::ldst_write_t ldst_write,
	output issue_pkg::rob_write_t rob_write
);
	import issue_pkg::*;

	decoded_t dec;
	reg_entry_t sr1_entry;
	reg_entry_t sr2_entry;
	reg_entry_t src_entry;
	reg_entry_t b_entry;
	operand_t opnd_a;
	operand_t opnd_b;
	logic sel_src_reg;
	logic rename_en;
	reg_idx_t rename_reg;
	rob_tag_t rename_tag;

	instr_decode u_decode (
		.instr(instr),
		.dec(dec)
	);

	reg_status u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.dec(dec),
		.rename_en(rename_en),
		.rename_reg(rename_reg),
		.rename_tag(rename_tag),
		.commit(commit),
		.sr1_entry(sr1_entry),
		.sr2_entry(sr2_entry),
		.src_entry(src_entry)
	);

	// Second operand is sr2, or the store source
	assign b_entry = sel_src_reg ? src_entry : sr2_entry;

	operand_resolve res_a (
		.entry(sr1_entry),
		.rob_val(rob_sr1),
		.cdb(cdb),
		.opnd(opnd_a)
	);

	operand_resolve res_b (
		.entry(b_entry),
		.rob_val(rob_sr2),
		.cdb(cdb),
		.opnd(opnd_b)
	);

	issue_control u_ctrl (
		.instr_is_new(instr_is_new),
		.dec(dec),
		.alu_busy(alu_busy),
		.ldst_full(ldst_full),
		.rob_full(rob_full),
		.rob_addr(rob_addr),
		.sr1_entry(sr1_entry),
		.src_entry(b_entry),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.stall(stall),
		.sel_src_reg(sel_src_reg),
		.rob_sr1_addr(rob_sr1_addr),
		.rob_sr2_addr(rob_sr2_addr),
		.rename_en(rename_en),
		.rename_reg(rename_reg),
		.rename_tag(rename_tag),
		.rs_write(rs_write),
		.ldst_write(ldst_write),
		.rob_write(rob_write)
	);

endmodule

/* operand_resolve.sv */
`timescale 1ns/1ps

module operand_resolve (
	input issue_pkg::reg_entry_t entry,
	input issue_pkg::operand_t rob_val,
	input issue_pkg::cdb_t cdb,
	output issue_pkg::operand_t opnd
);
	import issue_pkg::*;

	logic cdb_hit;

	assign cdb_hit = cdb.valid && (cdb.tag == entry.rob_entry);

	always_comb
	begin
		opnd = '0;
		if (!entry.busy)
		begin
			opnd.ready = 1'b1;
			opnd.value = entry.data;
		end
		else if (cdb_hit)	// Producer broadcasting right now
		begin
			opnd.ready = 1'b1;
			opnd.value = cdb.data;
		end
		else if (rob_val.ready)
		begin
			// Finished but not yet retired
			opnd.ready = 1'b1;
			opnd.value = rob_val.value;
		end
		else
		begin
			opnd.tag = entry.rob_entry;	// Wait on producer
		end
	end

endmodule

/* reg_status.sv */
`timescale 1ns/1ps

module reg_status (
	input logic clk,
	input logic rst_n,
	input issue_pkg::decoded_t dec,
	input logic rename_en,
	input issue_pkg::reg_idx_t rename_reg,
	input issue_pkg::rob_tag_t rename_tag,
	input issue_pkg::commit_t commit,
	output issue_pkg::reg_entry_t sr1_entry,
	output issue_pkg::reg_entry_t sr2_entry,
	output issue_pkg::reg_entry_t src_entry
);
	import issue_pkg::*;

	reg_entry_t regs [NUM_REGS];
	logic tag_match;

	// Only the newest producer may release the register
	assign tag_match = (regs[commit.dest].rob_entry == commit.tag);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (commit.valid)
			begin
				regs[commit.dest].data <= commit.data;	// Data always lands
				if (tag_match)
					regs[commit.dest].busy <= 1'b0;
			end

			// Later assignment, so a same-cycle rename beats the commit
			if (rename_en)
			begin
				regs[rename_reg].busy <= 1'b1;
				regs[rename_reg].rob_entry <= rename_tag;
			end
		end
	end

	// Read ports, no bypass from commit
	assign sr1_entry = regs[dec.sr1];
	assign sr2_entry = regs[dec.sr2];
	assign src_entry = regs[dec.dest];	// Store source sits in the dest field

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_issue_stage -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);
	localparam int HALF_PERIOD = 5;	// 10 ns period
	localparam int RESET_CYCLES = 8;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* tb_issue_assertions.sv */
`timescale 1ns/1ps

module tb_issue_assertions (
	input logic clk,
	input logic rst_n,
	input logic instr_is_new,
	input logic stall,
	input issue_pkg::rs_write_t rs_write,
	input issue_pkg::ldst_write_t ldst_write,
	input issue_pkg::rob_write_t rob_write
);
	logic any_write;

	assign any_write = rs_write.enable || ldst_write.enable || rob_write.enable;

	stall_blocks_writes: assert property (@(posedge clk) disable iff (!rst_n)
		stall |-> !any_write)
		else $error("Write enable high during a stall");

	one_target: assert property (@(posedge clk) disable iff (!rst_n)
		!(rs_write.enable && ldst_write.enable))
		else $error("Station and load/store buffer written together");

	// Nothing may issue without a waiting instruction
	idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!instr_is_new |-> !any_write)
		else $error("Write enable high with no instruction waiting");

endmodule

bind issue_stage tb_issue_assertions u_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.instr_is_new(instr_is_new),
	.stall(stall),
	.rs_write(rs_write),
	.ldst_write(ldst_write),
	.rob_write(rob_write)
);

/* tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage;
	import issue_pkg::*;

	localparam int PRELOAD_CYCLES = NUM_REGS + 2;	// Two idle cycles first
	localparam int RANDOM_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = 2200;	// About ten percent above the test length
	localparam logic [31:0] SEED = 32'hf327d83d;

	typedef struct packed {
		logic stall;
		logic rename;
		rob_tag_t rob_sr1_addr;
		rob_tag_t rob_sr2_addr;
		rs_write_t rs_write;
		ldst_write_t ldst_write;
		rob_write_t rob_write;
	} expect_t;

	logic clk;
	logic rst_n;
	word_t instr;
	logic instr_is_new;
	cdb_t cdb;
	logic [NUM_ALU_STATIONS-1:0] alu_busy;
	logic ldst_full;
	logic rob_full;
	rob_tag_t rob_addr;
	operand_t rob_sr1;
	operand_t rob_sr2;
	commit_t commit;
	logic stall;
	rob_tag_t rob_sr1_addr;
	rob_tag_t rob_sr2_addr;
	rs_write_t rs_write;
	ldst_write_t ldst_write;
	rob_write_t rob_write;

	// Register status model
	word_t model_data [NUM_REGS];
	logic model_busy [NUM_REGS];
	rob_tag_t model_tag [NUM_REGS];

	string test_name = "reset";
	int cycle_count = 0;
	logic stalled_last = 1'b0;
	expect_t exp_now;

	tb_clock u_clock (
		.clk(clk),
		.rst_n(rst_n)
	);

	issue_stage dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.instr_is_new(instr_is_new),
		.cdb(cdb),
		.alu_busy(alu_busy),
		.ldst_full(ldst_full),
		.rob_full(rob_full),
		.rob_addr(rob_addr),
		.rob_sr1(rob_sr1),
		.rob_sr2(rob_sr2),
		.commit(commit),
		.stall(stall),
		.rob_sr1_addr(rob_sr1_addr),
		.rob_sr2_addr(rob_sr2_addr),
		.rs_write(rs_write),
		.ldst_write(ldst_write),
		.rob_write(rob_write)
	);

	function automatic operand_t resolve(input reg_idx_t r, input operand_t rob_val);
		operand_t o;
		o = '0;
		if (!model_busy[r])
		begin
			o.ready = 1'b1;
			o.value = model_data[r];
		end
		else if (cdb.valid && cdb.tag == model_tag[r])
		begin
			o.ready = 1'b1;	// Broadcast this cycle
			o.value = cdb.data;
		end
		else if (rob_val.ready)
		begin
			o.ready = 1'b1;
			o.value = rob_val.value;
		end
		else
			o.tag = model_tag[r];
		return o;
	endfunction

	// Expected outputs from the current inputs and the model
	function automatic expect_t predict();
		opcode_t op;
		reg_idx_t dest;
		reg_idx_t sr1;
		reg_idx_t sr2;
		word_t imm;
		word_t off;
		logic alu;
		logic load;
		logic store;
		operand_t a;
		operand_t b;
		station_id_t st;
		expect_t e;
		op = opcode_t'(instr[15:12]);
		dest = instr[11:9];
		sr1 = instr[8:6];
		sr2 = instr[2:0];
		imm = {{11{instr[4]}}, instr[4:0]};
		off = {{10{instr[5]}}, instr[5:0]};
		if (op == op_ldr || op == op_str)
			off = {off[14:0], 1'b0};	// Word offset
		alu = (op == op_add) || (op == op_and) || (op == op_not) || (op == op_shf);
		load = (op == op_ldr) || (op == op_ldb);
		store = (op == op_str) || (op == op_stb);
		if (!alu_busy[0])
			st = 2'd0;
		else if (!alu_busy[1])
			st = 2'd1;
		else
			st = 2'd2;

		e = '0;
		e.rob_sr1_addr = model_tag[sr1];
		e.rob_sr2_addr = store ? model_tag[dest] : model_tag[sr2];
		e.stall = instr_is_new && ((rob_full && (alu || load || store)) ||
			(alu && (&alu_busy)) || (ldst_full && (load || store)));
		if (instr_is_new && !e.stall && (alu || load || store))
		begin
			a = resolve(sr1, rob_sr1);
			b = resolve(store ? dest : sr2, rob_sr2);
			e.rename = !store;
			e.rob_write = '{enable: 1'b1, opcode: op, dest: store ? 3'd0 : dest};
			if (alu)
			begin
				e.rs_write.enable = 1'b1;
				e.rs_write.station = st;
				e.rs_write.opcode = op;
				e.rs_write.dest = rob_addr;
				e.rs_write.j = a;
				if (instr[5] || op == op_shf)
					e.rs_write.k = '{ready: 1'b1, value: imm, tag: 3'd0};
				else
					e.rs_write.k = b;
			end
			else
			begin
				e.ldst_write.enable = 1'b1;
				e.ldst_write.opcode = op;
				e.ldst_write.dest = store ? 3'd0 : rob_addr;
				e.ldst_write.offset = off;
				e.ldst_write.base = a;
				if (store)
					e.ldst_write.src = b;
			end
		end
		return e;
	endfunction

	task automatic check_value(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch in %s, %s: expected %h, actual %h",
				test_name, field, expected, actual);
			$display("Checks failed");
			$fatal(1, "Stopping at first error");
		end
	endtask

	function automatic opcode_t pick_opcode();
		case ($urandom_range(0, 9))
			0: return op_add;
			1: return op_and;
			2: return op_not;
			3: return op_shf;
			4: return op_ldr;
			5: return op_ldb;
			6: return op_str;
			7: return op_stb;
			default: return opcode_t'(4'($urandom));	// Any opcode
		endcase
	endfunction

	task automatic drive_random_cycle();
		reg_idx_t r;
		r = 3'($urandom);
		if (!stalled_last)
		begin
			instr <= {pick_opcode(), 12'($urandom)};
			instr_is_new <= ($urandom_range(0, 3) != 0);
		end
		alu_busy <= 3'($urandom);
		ldst_full <= ($urandom_range(0, 5) == 0);
		rob_full <= ($urandom_range(0, 5) == 0);
		rob_addr <= 3'($urandom);
		cdb <= '{valid: 1'($urandom), tag: 3'($urandom), data: 16'($urandom)};
		rob_sr1 <= '{ready: ($urandom_range(0, 2) == 0), value: 16'($urandom),
			tag: 3'($urandom)};
		rob_sr2 <= '{ready: ($urandom_range(0, 2) == 0), value: 16'($urandom),
			tag: 3'($urandom)};
		// Half the commits carry the current tag, the rest are often stale
		commit <= '{valid: 1'($urandom), dest: r,
			tag: ($urandom_range(0, 1) == 1) ? model_tag[r] : 3'($urandom),
			data: 16'($urandom)};
	endtask

	always @(posedge clk or negedge rst_n)
	begin : model_update
		expect_t upd;
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				model_data[i] <= '0;
				model_busy[i] <= 1'b0;
				model_tag[i] <= '0;
			end
		end
		else
		begin
			upd = predict();
			if (commit.valid)
			begin
				model_data[commit.dest] <= commit.data;
				if (model_tag[commit.dest] == commit.tag)
					model_busy[commit.dest] <= 1'b0;
			end
			if (upd.rename)
			begin
				model_busy[instr[11:9]] <= 1'b1;	// Overrides a same-cycle commit
				model_tag[instr[11:9]] <= rob_addr;
			end
		end
	end

	// Outputs are settled half a cycle after the inputs change
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			exp_now = predict();
			check_value("stall", 64'(exp_now.stall), 64'(stall));
			check_value("rob_sr1_addr", 64'(exp_now.rob_sr1_addr), 64'(rob_sr1_addr));
			check_value("rob_sr2_addr", 64'(exp_now.rob_sr2_addr), 64'(rob_sr2_addr));
			check_value("rs_write", 64'(exp_now.rs_write), 64'(rs_write));
			check_value("ldst_write", 64'(exp_now.ldst_write), 64'(ldst_write));
			check_value("rob_write", 64'(exp_now.rob_write), 64'(rob_write));
			stalled_last = stall && instr_is_new;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		void'($urandom(SEED));
		instr = '0;
		instr_is_new = 1'b0;
		cdb = '0;
		alu_busy = '0;
		ldst_full = 1'b0;
		rob_full = 1'b0;
		rob_addr = '0;
		rob_sr1 = '0;
		rob_sr2 = '0;
		commit = '0;

		@(posedge rst_n);
		test_name = "idle";
		repeat (PRELOAD_CYCLES - NUM_REGS)
		begin
			@(posedge clk);
			instr <= {pick_opcode(), 12'($urandom)};	// Nothing waiting yet
		end

		test_name = "reset_read";
		for (int i = 0; i < NUM_REGS; i++)
		begin
			@(posedge clk);
			// Stores read sr1 and the dest field without renaming
			instr <= {op_str, reg_idx_t'(i), reg_idx_t'(NUM_REGS - 1 - i), 6'($urandom)};
			instr_is_new <= 1'b1;
		end

		test_name = "preload";
		for (int i = 0; i < NUM_REGS; i++)
		begin
			@(posedge clk);
			instr_is_new <= 1'b0;
			commit <= '{valid: 1'b1, dest: reg_idx_t'(i), tag: 3'd0, data: 16'($urandom)};
		end

		test_name = "random";
		repeat (RANDOM_CYCLES)
		begin
			@(posedge clk);
			drive_random_cycle();
		end

		@(negedge clk);
		#1;
		$display("All checks passed");
		$finish;
	end

endmodule

/* verilog.f */
issue_pkg.sv
instr_decode.sv
reg_status.sv
operand_resolve.sv
issue_control.sv
issue_stage.sv
tb_clock.sv
tb_issue_assertions.sv
tb_issue_stage.sv
